//--- logic/rx_frame_pkg.sv
package rx_frame_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [31:0] csum_t;
  typedef logic [15:0] line_t;
  typedef logic [12:0] pos_idx_t;
  typedef logic [7:0]  report_code_t;

  // sync word as it appears on the stream
  localparam byte_t SYNC_HI = 8'hF5;
  localparam byte_t SYNC_LO = 8'h0A;

  localparam int HDR_BYTES  = 4;
  localparam int CSUM_BYTES = 4;

  typedef enum logic [7:0] {
    MSG_PIC_ROW = 8'h01,
    MSG_LED_ROW = 8'h02,
    MSG_ERASE   = 8'h10,
    MSG_RELEASE = 8'h11
  } msg_type_e;

  typedef enum logic [2:0] {
    FLD_SYNC,
    FLD_HEADER,
    FLD_PAYLOAD,
    FLD_CSUM
  } field_e;

  // position of the byte on in_data
  typedef struct packed {
    field_e   field;
    pos_idx_t idx;
    logic     strobe;
  } rx_pos_t;

  localparam report_code_t CODE_WRITE_ACK = 8'h12;
  localparam report_code_t CODE_CSUM_ERR  = 8'hFF;
  localparam report_code_t CODE_UNKNOWN   = 8'hFE;

  typedef struct packed {
    report_code_t code;
    logic [15:0]  arg;
  } rx_report_t;

endpackage

//--- logic/flash_cmd_pkg.sv
package flash_cmd_pkg;

  typedef logic [2:0]  region_t;
  typedef logic [13:0] row_t;

  // row is region in the top bits, line below
  localparam int LINE_BITS = 11;

  localparam region_t REGION_PIC = 3'd3;

  typedef enum logic {
    OP_ERASE,
    OP_WRITE
  } flash_op_e;

  typedef struct packed {
    flash_op_e op;
    row_t      row;
  } flash_cmd_t;

endpackage

//--- logic/rx_byte_counter.sv
module rx_byte_counter #(
  parameter int PAYLOAD_BYTES = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  rx_frame_pkg::byte_t     in_data,
  input  logic                    armed,
  input  logic                    has_payload,
  output rx_frame_pkg::rx_pos_t   rx_pos,
  output logic                    frame_end
);

  localparam rx_frame_pkg::pos_idx_t HDR_LAST =
    rx_frame_pkg::pos_idx_t'(rx_frame_pkg::HDR_BYTES - 1);
  localparam rx_frame_pkg::pos_idx_t PAY_LAST =
    rx_frame_pkg::pos_idx_t'(PAYLOAD_BYTES - 1);
  localparam rx_frame_pkg::pos_idx_t CSUM_LAST =
    rx_frame_pkg::pos_idx_t'(rx_frame_pkg::CSUM_BYTES - 1);

  rx_frame_pkg::field_e   field_q;
  rx_frame_pkg::field_e   field_next;
  rx_frame_pkg::pos_idx_t idx_q;
  rx_frame_pkg::byte_t    last_byte;
  logic                   hold_q;
  logic                   accept;
  logic                   field_last;

  // after a frame, wait for the FSM to drop armed before taking bytes again
  assign accept = in_valid && armed && !hold_q;

  assign rx_pos.field  = field_q;
  assign rx_pos.idx    = idx_q;
  assign rx_pos.strobe = accept;

  always_comb
  begin
    field_last = 1'b0;
    field_next = rx_frame_pkg::FLD_SYNC;
    case (field_q)
      rx_frame_pkg::FLD_HEADER:
      begin
        field_last = (idx_q == HDR_LAST);
        field_next = has_payload ? rx_frame_pkg::FLD_PAYLOAD : rx_frame_pkg::FLD_CSUM;
      end
      rx_frame_pkg::FLD_PAYLOAD:
      begin
        field_last = (idx_q == PAY_LAST);
        field_next = rx_frame_pkg::FLD_CSUM;
      end
      rx_frame_pkg::FLD_CSUM:
      begin
        field_last = (idx_q == CSUM_LAST);
      end
      default:
      begin
        field_last = (last_byte == rx_frame_pkg::SYNC_HI) && (in_data == rx_frame_pkg::SYNC_LO);
        field_next = rx_frame_pkg::FLD_HEADER;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      field_q   <= rx_frame_pkg::FLD_SYNC;
      idx_q     <= '0;
      last_byte <= '0;
      hold_q    <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      frame_end <= 1'b0;
      if (!armed)
        hold_q <= 1'b0;
      if (accept)
      begin
        last_byte <= in_data;
        idx_q     <= idx_q + 1'b1;
        if (field_q == rx_frame_pkg::FLD_SYNC)
          idx_q <= '0;
        if (field_last)
        begin
          idx_q   <= '0;
          field_q <= field_next;
        end
        // last checksum byte closes the frame
        if (field_last && field_q == rx_frame_pkg::FLD_CSUM)
        begin
          frame_end <= 1'b1;
          hold_q    <= 1'b1;
          last_byte <= '0;
        end
      end
    end
  end

endmodule

//--- logic/rx_header_capture.sv
module rx_header_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rx_frame_pkg::byte_t       in_data,
  input  rx_frame_pkg::rx_pos_t     rx_pos,
  input  logic                      frame_clear,
  output rx_frame_pkg::msg_type_e   msg_type,
  output rx_frame_pkg::line_t       line,
  output rx_frame_pkg::byte_t       led_id,
  output logic                      has_payload,
  output flash_cmd_pkg::flash_cmd_t cmd
);

  rx_frame_pkg::byte_t     erase_hi;
  rx_frame_pkg::byte_t     led_hi;
  flash_cmd_pkg::region_t  erase_region;
  flash_cmd_pkg::region_t  led_region;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      msg_type <= rx_frame_pkg::msg_type_e'(8'h00);
      line     <= '0;
      led_id   <= '0;
    end
    else if (frame_clear)
    begin
      msg_type <= rx_frame_pkg::msg_type_e'(8'h00);
      line     <= '0;
      led_id   <= '0;
    end
    else if (rx_pos.strobe && rx_pos.field == rx_frame_pkg::FLD_HEADER)
    begin
      case (rx_pos.idx)
        13'd0: msg_type <= rx_frame_pkg::msg_type_e'(in_data);
        13'd1: line[15:8] <= in_data;
        13'd2: line[7:0] <= in_data;
        13'd3: led_id <= in_data;
        default: ;
      endcase
    end
  end

  assign has_payload = (msg_type == rx_frame_pkg::MSG_PIC_ROW) ||
                       (msg_type == rx_frame_pkg::MSG_LED_ROW);

  // regions are numbered from 1
  assign erase_hi     = line[15:8] + 8'd1;
  assign led_hi       = led_id + 8'd1;
  assign erase_region = erase_hi[2:0];
  assign led_region   = led_hi[2:0];

  always_comb
  begin
    cmd.op  = flash_cmd_pkg::OP_WRITE;
    cmd.row = {flash_cmd_pkg::REGION_PIC, line[flash_cmd_pkg::LINE_BITS-1:0]};
    case (msg_type)
      rx_frame_pkg::MSG_ERASE:
      begin
        cmd.op  = flash_cmd_pkg::OP_ERASE;
        cmd.row = {erase_region, 11'd0};
      end
      rx_frame_pkg::MSG_LED_ROW:
        cmd.row = {led_region, line[flash_cmd_pkg::LINE_BITS-1:0]};
      default: ;
    endcase
  end

endmodule

//--- logic/rx_word_sum.sv
module rx_word_sum #(
  parameter int PAYLOAD_BYTES = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rx_frame_pkg::byte_t   in_data,
  input  rx_frame_pkg::rx_pos_t rx_pos,
  input  logic                  frame_end,
  input  logic                  frame_clear,
  output logic                  pay_valid,
  output rx_frame_pkg::word_t   pay_word,
  output logic                  sum_valid,
  output logic                  sum_ok
);

  rx_frame_pkg::byte_t    hi_q;
  rx_frame_pkg::word_t    word_in;
  rx_frame_pkg::csum_t    sum_q;
  rx_frame_pkg::csum_t    csum_rx_q;
  logic                   in_summed;
  logic                   in_pay;
  logic                   in_csum;

  assign word_in   = {hi_q, in_data};
  assign in_pay    = rx_pos.strobe && rx_pos.field == rx_frame_pkg::FLD_PAYLOAD;
  assign in_csum   = rx_pos.strobe && rx_pos.field == rx_frame_pkg::FLD_CSUM;
  assign in_summed = in_pay || (rx_pos.strobe && rx_pos.field == rx_frame_pkg::FLD_HEADER);

  always_ff @(posedge clk)
  begin
    if (in_summed && !rx_pos.idx[0])
      hi_q <= in_data;
    if (in_pay && rx_pos.idx[0])
      pay_word <= word_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pay_valid <= 1'b0;
      sum_valid <= 1'b0;
      sum_ok    <= 1'b0;
      sum_q     <= '0;
      csum_rx_q <= '0;
    end
    else
    begin
      pay_valid <= in_pay && rx_pos.idx[0];
      sum_valid <= frame_end;
      if (frame_clear)
      begin
        sum_q     <= '0;
        csum_rx_q <= '0;
      end
      else
      begin
        if (in_summed && rx_pos.idx[0])
          sum_q <= sum_q + {16'h0000, word_in};
        // checksum arrives big-endian
        if (in_csum)
          csum_rx_q <= {csum_rx_q[23:0], in_data};
      end
      if (frame_end)
        sum_ok <= (sum_q == csum_rx_q);
    end
  end

endmodule

//--- logic/rx_ctrl_fsm.sv
module rx_ctrl_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sum_valid,
  input  logic                      sum_ok,
  input  rx_frame_pkg::msg_type_e   msg_type,
  input  rx_frame_pkg::line_t       line,
  input  flash_cmd_pkg::flash_cmd_t cmd,
  input  logic                      flash_ack,
  output logic                      armed,
  output logic                      frame_clear,
  output logic                      flash_req,
  output flash_cmd_pkg::flash_cmd_t flash_cmd,
  output logic                      pay_flush,
  output logic                      rpt_valid,
  output rx_frame_pkg::rx_report_t  rpt,
  output logic                      busy,
  output logic                      rx_full
);

  typedef enum logic [2:0] {
    RECEIVE,
    CHECK,
    FLASH_REQ,
    FLASH_WAIT,
    DONE
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  logic                     ok_q;
  logic                     is_write;
  logic                     is_erase;
  logic                     is_release;
  logic                     do_flash;
  rx_frame_pkg::rx_report_t rpt_d;

  assign is_write   = (msg_type == rx_frame_pkg::MSG_PIC_ROW) ||
                      (msg_type == rx_frame_pkg::MSG_LED_ROW);
  assign is_erase   = (msg_type == rx_frame_pkg::MSG_ERASE);
  assign is_release = (msg_type == rx_frame_pkg::MSG_RELEASE);
  assign do_flash   = ok_q && (is_write || is_erase);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RECEIVE:    if (sum_valid) state_d = CHECK;
      CHECK:      state_d = do_flash ? FLASH_REQ : DONE;
      FLASH_REQ:  if (flash_ack) state_d = FLASH_WAIT;
      // operation counts as finished once ack is back low
      FLASH_WAIT: if (!flash_ack) state_d = DONE;
      default:    state_d = RECEIVE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= RECEIVE;
      ok_q      <= 1'b0;
      busy      <= 1'b0;
      flash_cmd <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == RECEIVE && sum_valid)
      begin
        ok_q      <= sum_ok;
        flash_cmd <= cmd;
      end
      if (state_q == CHECK && ok_q && is_erase)
        busy <= 1'b1;
      else if (state_q == CHECK && ok_q && is_release)
        busy <= 1'b0;
    end
  end

  always_comb
  begin
    rpt_d.code = rx_frame_pkg::CODE_CSUM_ERR;
    rpt_d.arg  = '0;
    if (ok_q && is_write)
    begin
      rpt_d.code = rx_frame_pkg::CODE_WRITE_ACK;
      rpt_d.arg  = line;
    end
    else if (ok_q && (is_erase || is_release))
    begin
      rpt_d.code = msg_type;
      rpt_d.arg  = {8'h00, line[15:8]};
    end
    else if (ok_q)
      rpt_d.code = rx_frame_pkg::CODE_UNKNOWN;
  end

  assign armed       = (state_q == RECEIVE);
  assign frame_clear = (state_q == DONE);
  assign rpt_valid   = (state_q == CHECK);
  assign rpt         = rpt_valid ? rpt_d : '0;
  assign flash_req   = (rpt_valid && do_flash) || (state_q == FLASH_REQ);
  assign rx_full     = flash_req || (state_q == FLASH_WAIT);
  // only a good row keeps its payload words
  assign pay_flush   = rpt_valid && !(ok_q && is_write);

endmodule

//--- logic/rx_frame_top.sv
module rx_frame_top #(
  parameter int PAYLOAD_BYTES = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  rx_frame_pkg::byte_t       in_data,
  output logic                      pay_valid,
  output rx_frame_pkg::word_t       pay_word,
  output logic                      pay_flush,
  output logic                      flash_req,
  output flash_cmd_pkg::flash_cmd_t flash_cmd,
  input  logic                      flash_ack,
  input  logic                      flash_done_err,
  output logic                      rpt_valid,
  output rx_frame_pkg::rx_report_t  rpt,
  output logic                      busy,
  output logic                      rx_full
);

  rx_frame_pkg::rx_pos_t     rx_pos;
  logic                      frame_end;
  logic                      has_payload;
  flash_cmd_pkg::flash_cmd_t cmd;
  rx_frame_pkg::msg_type_e   msg_type;
  rx_frame_pkg::line_t       line;
  logic                      sum_valid;
  logic                      sum_ok;
  logic                      armed;
  logic                      frame_clear;

  rx_byte_counter #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES)
  ) byte_counter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .armed       (armed),
    .has_payload (has_payload),
    .rx_pos      (rx_pos),
    .frame_end   (frame_end)
  );

  // panel id only feeds the row decode inside header capture
  rx_header_capture header_capture_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data     (in_data),
    .rx_pos      (rx_pos),
    .frame_clear (frame_clear),
    .msg_type    (msg_type),
    .line        (line),
    .led_id      (),
    .has_payload (has_payload),
    .cmd         (cmd)
  );

  rx_word_sum #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES)
  ) word_sum_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data     (in_data),
    .rx_pos      (rx_pos),
    .frame_end   (frame_end),
    .frame_clear (frame_clear),
    .pay_valid   (pay_valid),
    .pay_word    (pay_word),
    .sum_valid   (sum_valid),
    .sum_ok      (sum_ok)
  );

  // flash completion is taken from the ack alone
  rx_ctrl_fsm ctrl_fsm_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sum_valid   (sum_valid),
    .sum_ok      (sum_ok),
    .msg_type    (msg_type),
    .line        (line),
    .cmd         (cmd),
    .flash_ack   (flash_ack),
    .armed       (armed),
    .frame_clear (frame_clear),
    .flash_req   (flash_req),
    .flash_cmd   (flash_cmd),
    .pay_flush   (pay_flush),
    .rpt_valid   (rpt_valid),
    .rpt         (rpt),
    .busy        (busy),
    .rx_full     (rx_full)
  );

endmodule

//--- verification/rx_frame_tb.sv
module rx_frame_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PAY_BYTES      = 16;
  localparam int REPORT_TIMEOUT = 60;
  localparam int FLASH_TIMEOUT  = 80;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  rx_frame_pkg::byte_t       in_data;
  logic                      pay_valid;
  rx_frame_pkg::word_t       pay_word;
  logic                      pay_flush;
  logic                      flash_req;
  flash_cmd_pkg::flash_cmd_t flash_cmd;
  logic                      flash_ack;
  logic                      flash_done_err;
  logic                      rpt_valid;
  rx_frame_pkg::rx_report_t  rpt;
  logic                      busy;
  logic                      rx_full;

  logic [31:0] lcg_state;
  int          errors = 0;
  int          resp_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_base;
  logic        idle_busy;

  // expected payload words of the frame in flight
  rx_frame_pkg::word_t exp_words[$];

  // logs written by the monitor and the flash model
  rx_frame_pkg::word_t       got_words[$];
  rx_frame_pkg::rx_report_t  rpt_log[$];
  logic                      rpt_flush_log[$];
  flash_cmd_pkg::flash_cmd_t cmd_log[$];
  int                        flush_count = 0;
  int                        req_count = 0;
  int                        full_gap = 0;
  logic                      req_prev = 1'b0;

  int word_base;
  int rpt_base;
  int cmd_base;
  int flush_base;
  int req_base;
  int gap_base;

  rx_frame_top #(
    .PAYLOAD_BYTES (PAY_BYTES)
  ) rx_frame_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .pay_valid      (pay_valid),
    .pay_word       (pay_word),
    .pay_flush      (pay_flush),
    .flash_req      (flash_req),
    .flash_cmd      (flash_cmd),
    .flash_ack      (flash_ack),
    .flash_done_err (flash_done_err),
    .rpt_valid      (rpt_valid),
    .rpt            (rpt),
    .busy           (busy),
    .rx_full        (rx_full)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // outputs sampled mid cycle
  always @(negedge clk)
  begin
    if (pay_valid)
      got_words.push_back(pay_word);
    if (rpt_valid)
    begin
      rpt_log.push_back(rpt);
      rpt_flush_log.push_back(pay_flush);
    end
    if (pay_flush)
      flush_count++;
    if (flash_req && !req_prev)
      req_count++;
    if ((flash_req || flash_ack) && !rx_full)
      full_gap++;
    req_prev = flash_req;
  end

  // four-phase flash responder with a latency that varies per operation
  initial
  begin : flash_model
    int lat;
    int cnt;
    flash_ack <= 1'b0;
    forever
    begin
      @(negedge clk);
      if (flash_req && !flash_ack)
      begin
        cmd_log.push_back(flash_cmd);
        lat = 1 + (cmd_log.size() % 3);
        repeat (lat) @(posedge clk);
        flash_ack <= 1'b1;
        cnt = 0;
        do
        begin
          @(negedge clk);
          cnt++;
        end
        while (flash_req && cnt < FLASH_TIMEOUT);
        if (flash_req)
        begin
          $display("flash request still high %0d cycles after ack was raised", cnt);
          resp_errors++;
        end
        @(posedge clk);
        flash_ack <= 1'b0;
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic mark_frame();
    word_base  = got_words.size();
    rpt_base   = rpt_log.size();
    cmd_base   = cmd_log.size();
    flush_base = flush_count;
    req_base   = req_count;
    gap_base   = full_gap;
    exp_words.delete();
  endtask

  task automatic begin_test();
    test_err_base = errors + resp_errors;
    mark_frame();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors + resp_errors > test_err_base)
    begin
      tests_failed++;
      $display("%s: failed", name);
    end
    else
      $display("%s: passed", name);
  endtask

  function automatic flash_cmd_pkg::flash_cmd_t frame_cmd();
    if (cmd_log.size() > cmd_base)
      return cmd_log[cmd_base];
    return '0;
  endfunction

  function automatic rx_frame_pkg::rx_report_t frame_report();
    if (rpt_log.size() > rpt_base)
      return rpt_log[rpt_base];
    return '0;
  endfunction

  task automatic send_byte(input rx_frame_pkg::byte_t b);
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= b;
  endtask

  // sync, header, payload for types 01 and 02, then the big-endian sum
  task automatic send_frame(input rx_frame_pkg::byte_t typ, input rx_frame_pkg::line_t ln,
                            input rx_frame_pkg::byte_t panel, input bit corrupt);
    rx_frame_pkg::byte_t body[$];
    rx_frame_pkg::csum_t sum;
    body.push_back(typ);
    body.push_back(ln[15:8]);
    body.push_back(ln[7:0]);
    body.push_back(panel);
    if (typ == 8'h01 || typ == 8'h02)
    begin
      for (int i = 0; i < PAY_BYTES; i++)
      begin
        lcg_state = lcg_next(lcg_state);
        body.push_back(lcg_state[23:16]);
      end
    end
    sum = '0;
    for (int i = 0; i < body.size(); i += 2)
    begin
      sum = sum + 32'({body[i], body[i+1]});
      if (i >= 4)
        exp_words.push_back({body[i], body[i+1]});
    end
    if (corrupt)
      sum = sum ^ 32'h0000_005A;
    send_byte(8'hF5);
    send_byte(8'h0A);
    foreach (body[i])
      send_byte(body[i]);
    for (int i = 3; i >= 0; i--)
      send_byte(sum[8*i +: 8]);
    @(posedge clk);
    in_valid <= 1'b0;
    in_data  <= '0;
  endtask

  task automatic wait_report(input string what);
    int cnt;
    cnt = 0;
    do
    begin
      @(negedge clk);
      cnt++;
    end
    while (!rpt_valid && cnt < REPORT_TIMEOUT);
    if (!rpt_valid)
    begin
      $display("timeout: %s got no report within %0d cycles", what, cnt);
      errors++;
    end
  endtask

  // wait for the flash to finish and leave a short gap so the counter is armed again
  task automatic wait_idle(input string what);
    int cnt;
    cnt = 0;
    do
    begin
      @(negedge clk);
      cnt++;
    end
    while (rx_full && cnt < FLASH_TIMEOUT);
    if (rx_full)
    begin
      $display("timeout: %s kept rx_full high for %0d cycles", what, cnt);
      errors++;
    end
    idle_busy = busy;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_words(input string what);
    check_value(32'(got_words.size() - word_base), 32'(exp_words.size()),
                {what, " payload word count"});
    for (int i = 0; i < exp_words.size() && word_base + i < got_words.size(); i++)
      check_value(32'(got_words[word_base + i]), 32'(exp_words[i]),
                  $sformatf("%s payload word %0d", what, i));
  endtask

  task automatic check_write(input string what, input rx_frame_pkg::line_t ln);
    rx_frame_pkg::rx_report_t  r;
    flash_cmd_pkg::flash_cmd_t c;
    r = frame_report();
    c = frame_cmd();
    check_value(32'(rpt_log.size() - rpt_base), 1, {what, " report count"});
    check_value(32'(r.code), 32'h12, {what, " report code"});
    check_value(32'(r.arg), 32'(ln), {what, " report arg"});
    check_value(32'(cmd_log.size() - cmd_base), 1, {what, " flash command count"});
    check_value(32'(c.op), 32'(flash_cmd_pkg::OP_WRITE), {what, " flash op"});
    check_value(32'(flush_count - flush_base), 0, {what, " flush pulses"});
  endtask

  task automatic test_pic_row();
    rx_frame_pkg::line_t       ln;
    flash_cmd_pkg::flash_cmd_t c;
    ln = 16'h0D23;
    begin_test();
    send_frame(8'h01, ln, 8'h00, 1'b0);
    wait_report("picture row");
    wait_idle("picture row");
    check_words("picture row");
    check_write("picture row", ln);
    c = frame_cmd();
    // region 3 with the line taken from the low 11 bits
    check_value(32'(c.row), 32'({3'd3, ln[10:0]}), "picture row flash row");
    check_value(32'(full_gap - gap_base), 0, "rx_full low samples during handshake");
    end_test("picture row write");
  endtask

  task automatic test_led_row();
    rx_frame_pkg::line_t       ln;
    rx_frame_pkg::byte_t       panel;
    flash_cmd_pkg::flash_cmd_t c;
    ln = 16'h0025;
    panel = 8'h01;
    begin_test();
    send_frame(8'h02, ln, panel, 1'b0);
    wait_report("indicator row");
    wait_idle("indicator row");
    check_words("indicator row");
    check_write("indicator row", ln);
    c = frame_cmd();
    check_value(32'(c.row[13:11]), 32'(3'd2), "indicator row region");
    end_test("indicator row write");
  endtask

  task automatic test_erase();
    rx_frame_pkg::line_t       ln;
    rx_frame_pkg::rx_report_t  r;
    flash_cmd_pkg::flash_cmd_t c;
    ln = 16'h0100;
    begin_test();
    send_frame(8'h10, ln, 8'h00, 1'b0);
    wait_report("erase");
    wait_idle("erase");
    r = frame_report();
    c = frame_cmd();
    check_value(32'(r.code), 32'h10, "erase report code");
    check_value(32'(r.arg), 32'(ln[15:8]), "erase report arg");
    check_value(32'(cmd_log.size() - cmd_base), 1, "erase flash command count");
    check_value(32'(c.op), 32'(flash_cmd_pkg::OP_ERASE), "erase flash op");
    check_value(32'(c.row), 32'({3'd2, 11'd0}), "erase flash row");
    check_value(32'(idle_busy), 1, "busy after erase");
    check_value(32'(flush_count - flush_base), 1, "erase flush pulses");
    check_value(32'(rpt_flush_log[rpt_base]), 1, "flush together with erase report");
    check_value(32'(got_words.size() - word_base), 0, "erase payload word count");
    end_test("region erase");
  endtask

  task automatic test_release();
    rx_frame_pkg::line_t      ln;
    rx_frame_pkg::rx_report_t r;
    ln = 16'h0700;
    begin_test();
    send_frame(8'h11, ln, 8'h00, 1'b0);
    wait_report("release");
    wait_idle("release");
    r = frame_report();
    check_value(32'(r.code), 32'h11, "release report code");
    check_value(32'(r.arg), 32'(ln[15:8]), "release report arg");
    check_value(32'(req_count - req_base), 0, "release flash requests");
    check_value(32'(idle_busy), 0, "busy after release");
    check_value(32'(flush_count - flush_base), 1, "release flush pulses");
    end_test("release");
  endtask

  task automatic test_bad_checksum();
    rx_frame_pkg::rx_report_t r;
    begin_test();
    send_frame(8'h01, 16'h0042, 8'h00, 1'b1);
    wait_report("corrupted frame");
    wait_idle("corrupted frame");
    r = frame_report();
    check_value(32'(r.code), 32'hFF, "corrupted frame report code");
    check_value(32'(r.arg), 0, "corrupted frame report arg");
    check_value(32'(flush_count - flush_base), 1, "corrupted frame flush pulses");
    check_value(32'(rpt_flush_log[rpt_base]), 1, "flush together with error report");
    check_value(32'(req_count - req_base), 0, "corrupted frame flash requests");
    // receiver must still take a good frame
    mark_frame();
    send_frame(8'h01, 16'h0043, 8'h00, 1'b0);
    wait_report("frame after error");
    wait_idle("frame after error");
    check_words("frame after error");
    check_write("frame after error", 16'h0043);
    end_test("checksum error and recovery");
  endtask

  task automatic test_sync_search();
    int  cycles;
    bit  seen;
    begin_test();
    send_byte(8'h3C);
    send_byte(8'hF5);
    send_byte(8'h5A);
    send_byte(8'h0A);
    send_byte(8'hF5);
    send_frame(8'h01, 16'h0210, 8'h00, 1'b0);
    // send_frame returns one edge after the last checksum byte
    cycles = 1;
    seen = 0;
    while (!seen && cycles < REPORT_TIMEOUT)
    begin
      @(negedge clk);
      if (rpt_valid)
        seen = 1;
      else
      begin
        @(posedge clk);
        cycles++;
      end
    end
    if (!seen)
    begin
      $display("timeout: no report after the frame behind garbage bytes");
      errors++;
    end
    else
      check_value(32'(cycles), 3, "cycles from last checksum byte to report");
    wait_idle("frame behind garbage");
    check_words("frame behind garbage");
    check_write("frame behind garbage", 16'h0210);
    end_test("sync search and report latency");
  endtask

  initial
  begin
    lcg_state = 32'hb0d8_59a7;
    rst_n          <= 1'b0;
    in_valid       <= 1'b0;
    in_data        <= '0;
    flash_done_err <= 1'b0;

    begin_test();
    @(posedge clk);
    @(negedge clk);
    check_value(32'({flash_req, pay_valid, pay_flush, rpt_valid, busy, rx_full}), 0,
                "outputs in reset");
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    end_test("reset state");

    test_pic_row();
    test_led_row();
    test_erase();
    test_release();
    test_bad_checksum();
    test_sync_search();

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, errors + resp_errors);
    if (errors + resp_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- sources.f
logic/rx_frame_pkg.sv
logic/flash_cmd_pkg.sv
logic/rx_byte_counter.sv
logic/rx_header_capture.sv
logic/rx_word_sum.sv
logic/rx_ctrl_fsm.sv
logic/rx_frame_top.sv
verification/rx_frame_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = rx_frame_tb
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
